// ==== hw/state_id_pkg.sv ====
package state_id_pkg;

    // --------------------------------------------------
    // Widths and sizes
    // --------------------------------------------------
    localparam int ID_WID  = 4;
    localparam int KEY_WID = 8;
    localparam int NUM_IDS = 2 ** ID_WID;

    // --------------------------------------------------
    // Types
    // --------------------------------------------------
    typedef logic [ID_WID-1:0]  id_t;
    typedef logic [KEY_WID-1:0] key_t;

    // Deletion sequence, in the order a normal delete walks through it
    typedef enum logic [3:0] {
        RESET          = 4'd0,
        IDLE           = 4'd1,
        REVMAP_REQ     = 4'd2,
        REVMAP_PENDING = 4'd3,
        DELETE_REQ     = 4'd4,
        DELETE_PENDING = 4'd5,
        DEALLOC_ID     = 4'd6,
        DONE           = 4'd7,
        ERROR          = 4'd8
    } delete_state_t;

endpackage : state_id_pkg

// ==== hw/db_intf.sv ====
`timescale 1ns/1ps

interface db_intf
    import state_id_pkg::*;
();

    logic req;
    logic rdy;
    key_t key;
    logic ack;
    logic error;

    // Side that issues delete-by-key requests
    modport requester (
        output req, key,
        input  rdy, ack, error
    );

    // Side that owns the keys and answers
    modport responder (
        input  req, key,
        output rdy, ack, error
    );

endinterface : db_intf

// ==== hw/mem_intf.sv ====
`timescale 1ns/1ps

// Write side of a simple RAM
interface mem_wr_intf
    import state_id_pkg::*;
();

    logic req;
    logic rdy;
    id_t  addr;
    key_t data;

    modport controller (
        output req, addr, data,
        input  rdy
    );

    modport memory (
        input  req, addr, data,
        output rdy
    );

endinterface : mem_wr_intf

// Read side, data returns one cycle after the request
interface mem_rd_intf
    import state_id_pkg::*;
();

    logic req;
    logic rdy;
    id_t  addr;
    logic ack;
    key_t data;

    modport controller (
        output req, addr,
        input  rdy, ack, data
    );

    modport memory (
        input  req, addr,
        output rdy, ack, data
    );

endinterface : mem_rd_intf

// ==== hw/id_allocator.sv ====
`timescale 1ns/1ps

module id_allocator
    import state_id_pkg::*;
(
    input  logic clk,
    input  logic srst,

    output logic init_done,

    input  logic alloc_req,
    output logic alloc_rdy,
    output id_t  alloc_id,

    input  logic dealloc_req,
    output logic dealloc_rdy,
    input  id_t  dealloc_id
);

    // --------------------------------------------------
    // Signals
    // --------------------------------------------------
    logic [NUM_IDS-1:0] used;
    id_t                init_cnt;
    logic               any_free;

    // --------------------------------------------------
    // Init sweep
    // --------------------------------------------------
    // One entry per cycle, done after the last ID
    always_ff @(posedge clk) begin
        if (srst) begin
            init_cnt  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt == id_t'(NUM_IDS - 1)) begin
                init_done <= 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // Lowest free ID
    // --------------------------------------------------
    // Scan from the top so the lowest clear bit wins
    always_comb begin
        alloc_id = '0;
        for (int i = NUM_IDS - 1; i >= 0; i--) begin
            if (!used[i]) begin
                alloc_id = id_t'(i);
            end
        end
    end

    assign any_free = ~&used;

    assign alloc_rdy   = init_done && any_free;
    assign dealloc_rdy = init_done;

    // --------------------------------------------------
    // Used bits
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (!init_done) begin
            used[init_cnt] <= 1'b0;
        end else begin
            if (alloc_req && alloc_rdy) begin
                used[alloc_id] <= 1'b1;
            end
            // An ID being freed is never the one being handed out
            if (dealloc_req && dealloc_rdy) begin
                used[dealloc_id] <= 1'b0;
            end
        end
    end

endmodule : id_allocator

// ==== hw/rev_map_ram.sv ====
`timescale 1ns/1ps

module rev_map_ram
    import state_id_pkg::*;
(
    input  logic       clk,
    input  logic       srst,

    mem_wr_intf.memory wr,
    mem_rd_intf.memory rd
);

    // --------------------------------------------------
    // Storage and sweep state
    // --------------------------------------------------
    key_t mem [NUM_IDS];

    id_t  init_cnt;
    logic init_done;

    // Zero every entry once after reset
    always_ff @(posedge clk) begin
        if (srst) begin
            init_cnt  <= '0;
            init_done <= 1'b0;
        end else if (!init_done) begin
            init_cnt <= init_cnt + 1'b1;
            if (init_cnt == id_t'(NUM_IDS - 1)) begin
                init_done <= 1'b1;
            end
        end
    end

    assign wr.rdy = init_done;

    // Write port, sweep has priority until it ends
    always_ff @(posedge clk) begin
        if (!init_done) begin
            mem[init_cnt] <= '0;
        end else if (wr.req) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // --------------------------------------------------
    // Read port
    // --------------------------------------------------
    assign rd.rdy = 1'b1;

    always_ff @(posedge clk) begin
        if (rd.req) begin
            rd.data <= mem[rd.addr];
        end
    end

    always_ff @(posedge clk) begin
        if (srst) begin
            rd.ack <= 1'b0;
        end else begin
            rd.ack <= rd.req;
        end
    end

endmodule : rev_map_ram

// ==== hw/state_id_manager.sv ====
`timescale 1ns/1ps

module state_id_manager
    import state_id_pkg::*;
(
    input  logic       clk,
    input  logic       srst,

    output logic       init_done,

    // Insert side
    output logic       insert_rdy,
    input  logic       insert_req,
    input  key_t       insert_key,
    output id_t        insert_id,
    output logic       insert_accept,

    // Delete by ID, from the application
    input  logic       delete_req,
    input  id_t        delete_id,
    output logic       delete_rdy,
    output logic       delete_ack,
    output logic       delete_error,
    output key_t       delete_key,

    // Delete by key, toward the key store
    db_intf.requester  del_by_key,

    output logic [7:0] delete_state_mon
);

    // --------------------------------------------------
    // Signals
    // --------------------------------------------------
    logic alloc_init_done;
    logic alloc_rdy;
    id_t  alloc_id;

    logic dealloc_req;
    logic dealloc_rdy;

    id_t  del_id_q;
    key_t del_key_q;

    delete_state_t state;
    delete_state_t nxt_state;

    mem_wr_intf revmap_wr ();
    mem_rd_intf revmap_rd ();

    // --------------------------------------------------
    // Allocator and reverse map
    // --------------------------------------------------
    id_allocator i_id_allocator (
        .clk         ( clk ),
        .srst        ( srst ),
        .init_done   ( alloc_init_done ),
        .alloc_req   ( insert_accept ),
        .alloc_rdy   ( alloc_rdy ),
        .alloc_id    ( alloc_id ),
        .dealloc_req ( dealloc_req ),
        .dealloc_rdy ( dealloc_rdy ),
        .dealloc_id  ( del_id_q )
    );

    rev_map_ram i_rev_map_ram (
        .clk  ( clk ),
        .srst ( srst ),
        .wr   ( revmap_wr ),
        .rd   ( revmap_rd )
    );

    assign init_done = alloc_init_done && revmap_wr.rdy;

    // Insert is combinational, both the ID and the RAM write land on the accepting edge
    assign insert_rdy    = alloc_rdy && revmap_wr.rdy;
    assign insert_accept = insert_req && insert_rdy;
    assign insert_id     = alloc_id;

    assign revmap_wr.req  = insert_accept;
    assign revmap_wr.addr = alloc_id;
    assign revmap_wr.data = insert_key;

    assign revmap_rd.addr = del_id_q;

    // --------------------------------------------------
    // Delete context
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (delete_req && delete_rdy) begin
            del_id_q <= delete_id;
        end
    end

    always_ff @(posedge clk) begin
        if (revmap_rd.ack) begin
            del_key_q <= revmap_rd.data;
        end
    end

    assign del_by_key.key = del_key_q;
    assign delete_key     = del_key_q;

    // --------------------------------------------------
    // Deletion FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            state <= RESET;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state      = state;
        delete_rdy     = 1'b0;
        delete_ack     = 1'b0;
        delete_error   = 1'b0;
        revmap_rd.req  = 1'b0;
        del_by_key.req = 1'b0;
        dealloc_req    = 1'b0;
        case (state)
            RESET: begin
                nxt_state = IDLE;
            end
            IDLE: begin
                // Hold off until both sweeps are finished
                delete_rdy = init_done;
                if (delete_req && init_done) nxt_state = REVMAP_REQ;
            end
            REVMAP_REQ: begin
                revmap_rd.req = 1'b1;
                if (revmap_rd.rdy) nxt_state = REVMAP_PENDING;
            end
            REVMAP_PENDING: begin
                if (revmap_rd.ack) nxt_state = DELETE_REQ;
            end
            DELETE_REQ: begin
                del_by_key.req = 1'b1;
                if (del_by_key.rdy) nxt_state = DELETE_PENDING;
            end
            DELETE_PENDING: begin
                if (del_by_key.ack) begin
                    // ID stays allocated when the key was not there
                    nxt_state = del_by_key.error ? ERROR : DEALLOC_ID;
                end
            end
            DEALLOC_ID: begin
                dealloc_req = 1'b1;
                if (dealloc_rdy) nxt_state = DONE;
            end
            DONE: begin
                delete_ack = 1'b1;
                nxt_state  = IDLE;
            end
            ERROR: begin
                delete_ack   = 1'b1;
                delete_error = 1'b1;
                nxt_state    = IDLE;
            end
            default: begin
                nxt_state = IDLE;
            end
        endcase
    end

    assign delete_state_mon = {4'b0000, state};

endmodule : state_id_manager

// ==== hw/key_presence_table.sv ====
`timescale 1ns/1ps

module key_presence_table
    import state_id_pkg::*;
(
    input  logic      clk,
    input  logic      srst,

    // Accepted inserts
    input  logic      insert_strobe,
    input  key_t      insert_key,

    // Delete-by-key requests
    db_intf.responder del
);

    // --------------------------------------------------
    // Signals
    // --------------------------------------------------
    logic [2**KEY_WID-1:0] present;
    logic                  rdy_q;
    logic                  del_accept;

    assign del.rdy    = rdy_q;
    assign del_accept = del.req && rdy_q;

    // --------------------------------------------------
    // Presence bits and response
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (srst) begin
            present   <= '0;
            rdy_q     <= 1'b0;
            del.ack   <= 1'b0;
            del.error <= 1'b0;
        end else begin
            rdy_q     <= 1'b1;
            // Answer one cycle after the request is taken
            del.ack   <= del_accept;
            del.error <= del_accept && !present[del.key];
            if (del_accept) begin
                present[del.key] <= 1'b0;
            end
            // Insert last, a same-cycle insert of the key keeps it present
            if (insert_strobe) begin
                present[insert_key] <= 1'b1;
            end
        end
    end

endmodule : key_presence_table

// ==== hw/state_tracker_top.sv ====
`timescale 1ns/1ps

module state_tracker_top
    import state_id_pkg::*;
(
    input  logic       clk,
    input  logic       srst,

    input  logic       insert_req,
    input  key_t       insert_key,
    output logic       insert_rdy,
    output id_t        insert_id,

    input  logic       delete_req,
    input  id_t        delete_id,
    output logic       delete_rdy,
    output logic       delete_ack,
    output logic       delete_error,
    output key_t       delete_key,

    output logic       init_done,
    output logic [7:0] delete_state_mon
);

    logic insert_accept;

    db_intf del_if ();

    // --------------------------------------------------
    // ID side and key side
    // --------------------------------------------------
    state_id_manager i_state_id_manager (
        .clk              ( clk ),
        .srst             ( srst ),
        .init_done        ( init_done ),
        .insert_rdy       ( insert_rdy ),
        .insert_req       ( insert_req ),
        .insert_key       ( insert_key ),
        .insert_id        ( insert_id ),
        .insert_accept    ( insert_accept ),
        .delete_req       ( delete_req ),
        .delete_id        ( delete_id ),
        .delete_rdy       ( delete_rdy ),
        .delete_ack       ( delete_ack ),
        .delete_error     ( delete_error ),
        .delete_key       ( delete_key ),
        .del_by_key       ( del_if ),
        .delete_state_mon ( delete_state_mon )
    );

    key_presence_table i_key_presence_table (
        .clk           ( clk ),
        .srst          ( srst ),
        .insert_strobe ( insert_accept ),
        .insert_key    ( insert_key ),
        .del           ( del_if )
    );

endmodule : state_tracker_top

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic srst
);

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Reset held for ten rising edges, released just after the last one
    initial begin
        srst = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        srst = 1'b0;
    end

endmodule : tb_clock_gen

// ==== bench/state_tracker_checker.sv ====
`timescale 1ns/1ps

module state_tracker_checker
    import state_id_pkg::*;
(
    input  logic       clk,
    input  logic       srst,
    input  logic       init_done,
    input  logic       insert_req,
    input  key_t       insert_key,
    input  logic       insert_rdy,
    input  id_t        insert_id,
    input  logic       delete_req,
    input  id_t        delete_id,
    input  logic       delete_rdy,
    input  logic       delete_ack,
    input  logic       delete_error,
    input  key_t       delete_key,
    input  logic [7:0] delete_state_mon,
    output int         err_cnt
);

    // --------------------------------------------------
    // Reference model state
    // --------------------------------------------------
    logic [NUM_IDS-1:0]    id_free;
    key_t                  id_key [NUM_IDS];
    logic [2**KEY_WID-1:0] key_present;
    logic                  in_flight;
    id_t                   del_id;
    int                    errs = 0;

    assign err_cnt = errs;

    function automatic id_t lowest_free(input logic [NUM_IDS-1:0] free_mask);
        id_t id;
        id = '0;
        for (int i = 0; i < NUM_IDS; i++) begin
            if (free_mask[i]) begin
                id = id_t'(i);
                break;
            end
        end
        return id;
    endfunction

    task automatic report_mismatch(input string name, input logic [7:0] got,
                                   input logic [7:0] exp);
        $display("error %s: got 0x%02h expected 0x%02h", name, got, exp);
        errs++;
    endtask

    // --------------------------------------------------
    // Compare at the falling edge where inputs and outputs are settled
    // --------------------------------------------------
    always @(negedge clk) begin
        key_t       exp_key;
        logic       exp_err;
        id_t        exp_id;
        logic [7:0] exp_mon;
        if (srst) begin
            id_free     = '1;
            key_present = '0;
            in_flight   = 1'b0;
            for (int i = 0; i < NUM_IDS; i++) begin
                id_key[i] = '0;
            end
            // Status outputs are all low while reset is held
            if ({insert_rdy, delete_rdy, delete_ack, delete_error, init_done} !== 5'b0) begin
                report_mismatch("{insert_rdy,delete_rdy,delete_ack,delete_error,init_done}",
                                {3'h0, insert_rdy, delete_rdy, delete_ack, delete_error,
                                 init_done}, 8'h00);
            end
            if (delete_state_mon !== 8'(RESET)) begin
                report_mismatch("delete_state_mon", delete_state_mon, 8'(RESET));
            end
        end else begin
            if (in_flight && delete_rdy) begin
                report_mismatch("delete_rdy", {7'h0, delete_rdy}, 8'h00);
            end
            if (init_done && !in_flight && delete_state_mon !== 8'(IDLE)) begin
                report_mismatch("delete_state_mon", delete_state_mon, 8'(IDLE));
            end
            // Delete side first so an ID freed here is visible to an insert
            if (delete_ack) begin
                if (!in_flight) begin
                    $display("delete_ack came while no delete was in flight");
                    errs++;
                end
                exp_key = id_key[del_id];
                exp_err = !key_present[exp_key];
                exp_mon = exp_err ? 8'(ERROR) : 8'(DONE);
                if (delete_key !== exp_key) begin
                    report_mismatch("delete_key", delete_key, exp_key);
                end
                if (delete_error !== exp_err) begin
                    report_mismatch("delete_error", {7'h0, delete_error}, {7'h0, exp_err});
                end
                if (delete_state_mon !== exp_mon) begin
                    report_mismatch("delete_state_mon", delete_state_mon, exp_mon);
                end
                if (!exp_err) begin
                    key_present[exp_key] = 1'b0;
                    id_free[del_id]      = 1'b1;
                end
                in_flight = 1'b0;
            end
            if (insert_rdy !== (init_done && |id_free)) begin
                report_mismatch("insert_rdy", {7'h0, insert_rdy},
                                {7'h0, init_done && |id_free});
            end
            if (insert_req && insert_rdy) begin
                if (!(|id_free)) begin
                    $display("insert accepted although every ID was taken");
                    errs++;
                end else begin
                    exp_id = lowest_free(id_free);
                    if (insert_id !== exp_id) begin
                        report_mismatch("insert_id", {4'h0, insert_id}, {4'h0, exp_id});
                    end
                    id_free[exp_id]         = 1'b0;
                    id_key[exp_id]          = insert_key;
                    key_present[insert_key] = 1'b1;
                end
            end
            if (delete_req && delete_rdy) begin
                in_flight = 1'b1;
                del_id    = delete_id;
            end
        end
    end

endmodule : state_tracker_checker

// ==== bench/state_tracker_tb.sv ====
`timescale 1ns/1ps

module state_tracker_tb
    import state_id_pkg::*;
();

    typedef enum logic [1:0] {OP_INSERT, OP_DELETE, OP_DELINS, OP_FULL} op_t;

    logic       clk;
    logic       srst;
    logic       insert_req;
    key_t       insert_key;
    logic       insert_rdy;
    id_t        insert_id;
    logic       delete_req;
    id_t        delete_id;
    logic       delete_rdy;
    logic       delete_ack;
    logic       delete_error;
    key_t       delete_key;
    logic       init_done;
    logic [7:0] delete_state_mon;
    int         chk_errs;

    // Stimulus table with one entry per row in each queue
    op_t  row_op  [$];
    id_t  row_id  [$];
    key_t row_key [$];
    logic row_err [$];

    logic [2**KEY_WID-1:0] key_taken = '0;
    logic [31:0]           rng = 32'd36;
    int                    tb_errs = 0;
    int                    ack_cnt = 0;
    logic                  last_ack_err;
    int                    cycle_cnt = 0;
    int                    timeout_limit = 0;

    tb_clock_gen i_clock_gen (
        .clk  ( clk ),
        .srst ( srst )
    );

    state_tracker_top UUT (
        .clk              ( clk ),
        .srst             ( srst ),
        .insert_req       ( insert_req ),
        .insert_key       ( insert_key ),
        .insert_rdy       ( insert_rdy ),
        .insert_id        ( insert_id ),
        .delete_req       ( delete_req ),
        .delete_id        ( delete_id ),
        .delete_rdy       ( delete_rdy ),
        .delete_ack       ( delete_ack ),
        .delete_error     ( delete_error ),
        .delete_key       ( delete_key ),
        .init_done        ( init_done ),
        .delete_state_mon ( delete_state_mon )
    );

    state_tracker_checker i_checker (
        .clk              ( clk ),
        .srst             ( srst ),
        .init_done        ( init_done ),
        .insert_req       ( insert_req ),
        .insert_key       ( insert_key ),
        .insert_rdy       ( insert_rdy ),
        .insert_id        ( insert_id ),
        .delete_req       ( delete_req ),
        .delete_id        ( delete_id ),
        .delete_rdy       ( delete_rdy ),
        .delete_ack       ( delete_ack ),
        .delete_error     ( delete_error ),
        .delete_key       ( delete_key ),
        .delete_state_mon ( delete_state_mon ),
        .err_cnt          ( chk_errs )
    );

    // --------------------------------------------------
    // Table building
    // --------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Nonzero and unused since key 0 is what the init sweep leaves in the RAM
    task automatic new_key(output key_t key);
        do begin
            rng = xorshift32(rng);
            key = rng[7:0];
        end while (key == '0 || key_taken[key]);
        key_taken[key] = 1'b1;
    endtask

    task automatic add_row(input op_t op, input id_t id, input key_t key, input logic err);
        row_op.push_back(op);
        row_id.push_back(id);
        row_key.push_back(key);
        row_err.push_back(err);
    endtask

    task automatic build_table();
        key_t k;
        repeat (4) begin
            new_key(k);
            add_row(OP_INSERT, '0, k, 1'b0);
        end
        add_row(OP_DELETE, 4'd1, '0, 1'b0);
        new_key(k);
        add_row(OP_INSERT, '0, k, 1'b0);
        // Never allocated so the RAM still holds zero there
        add_row(OP_DELETE, 4'd9, '0, 1'b1);
        new_key(k);
        add_row(OP_INSERT, '0, k, 1'b0);
        add_row(OP_DELETE, 4'd2, '0, 1'b0);
        add_row(OP_DELETE, 4'd2, '0, 1'b1);
        new_key(k);
        add_row(OP_DELINS, 4'd0, k, 1'b0);
        // Twelve free IDs left at this point
        repeat (12) begin
            new_key(k);
            add_row(OP_INSERT, '0, k, 1'b0);
        end
        new_key(k);
        add_row(OP_FULL, '0, k, 1'b1);
        add_row(OP_DELETE, 4'd7, '0, 1'b0);
        new_key(k);
        add_row(OP_INSERT, '0, k, 1'b0);
        add_row(OP_FULL, '0, k, 1'b1);
    endtask

    // --------------------------------------------------
    // Drivers that change inputs 1 ns after the rising edge
    // --------------------------------------------------
    task automatic drive_insert(input key_t key);
        logic taken;
        taken      = 1'b0;
        insert_req = 1'b1;
        insert_key = key;
        while (!taken) begin
            @(negedge clk);
            taken = insert_rdy;
            @(posedge clk);
            #1;
        end
        insert_req = 1'b0;
    endtask

    task automatic hold_insert(input key_t key, input logic refuse);
        insert_req = 1'b1;
        insert_key = key;
        repeat (4) begin
            @(negedge clk);
            if (insert_rdy !== !refuse) begin
                $display("error insert_rdy: got 0x%h expected 0x%h", insert_rdy, !refuse);
                tb_errs++;
            end
            @(posedge clk);
            #1;
        end
        insert_req = 1'b0;
    endtask

    task automatic drive_delete(input id_t id);
        logic taken;
        taken      = 1'b0;
        delete_req = 1'b1;
        delete_id  = id;
        while (!taken) begin
            @(negedge clk);
            taken = delete_rdy;
            @(posedge clk);
            #1;
        end
        delete_req = 1'b0;
    endtask

    task automatic wait_delete_ack(input int start_cnt, input logic exp_err);
        while (ack_cnt == start_cnt) begin
            @(posedge clk);
        end
        #1;
        if (last_ack_err !== exp_err) begin
            $display("error delete_error: got 0x%h expected 0x%h", last_ack_err, exp_err);
            tb_errs++;
        end
    endtask

    task automatic print_counts();
        $display("rows %0d, checker errors %0d, table errors %0d",
                 row_op.size(), chk_errs, tb_errs);
    endtask

    always @(negedge clk) begin
        if (delete_ack === 1'b1) begin
            ack_cnt      = ack_cnt + 1;
            last_ack_err = delete_error;
        end
    end

    // Watchdog
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit) begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            print_counts();
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        int start;
        insert_req = 1'b0;
        insert_key = '0;
        delete_req = 1'b0;
        delete_id  = '0;
        build_table();
        timeout_limit = row_op.size() * 20 + 100;

        do begin
            @(negedge clk);
        end while (init_done !== 1'b1);
        @(posedge clk);
        #1;

        for (int r = 0; r < row_op.size(); r++) begin
            case (row_op[r])
                OP_INSERT: begin
                    drive_insert(row_key[r]);
                end
                OP_DELETE: begin
                    start = ack_cnt;
                    drive_delete(row_id[r]);
                    wait_delete_ack(start, row_err[r]);
                end
                OP_DELINS: begin
                    // Insert lands while the delete is still in flight
                    start = ack_cnt;
                    drive_delete(row_id[r]);
                    drive_insert(row_key[r]);
                    wait_delete_ack(start, row_err[r]);
                end
                default: begin
                    hold_insert(row_key[r], row_err[r]);
                end
            endcase
        end

        repeat (3) @(posedge clk);
        print_counts();
        if (chk_errs == 0 && tb_errs == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule : state_tracker_tb

// ==== vlog.f ====
hw/state_id_pkg.sv
hw/db_intf.sv
hw/mem_intf.sv
hw/id_allocator.sv
hw/rev_map_ram.sv
hw/state_id_manager.sv
hw/key_presence_table.sv
hw/state_tracker_top.sv
bench/tb_clock_gen.sv
bench/state_tracker_checker.sv
bench/state_tracker_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the state tracker testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module state_tracker_tb \
    -Mdir obj_dir -o state_tracker_sim -f vlog.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/state_tracker_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1
